//--- src/md5_cfg.svh
`ifndef MD5_CFG_SVH
`define MD5_CFG_SVH

// one pipeline stage per round
`define MD5_ROUNDS 64

// fixed message length, also the length word of the padding
`define MD5_MSG_BITS 64

// input register, all rounds, digest register
`define MD5_LATENCY (`MD5_ROUNDS + 2)

////////////////////////////////////////
// initial chaining value
////////////////////////////////////////

`define MD5_IV_A 32'h67452301
`define MD5_IV_B 32'hefcdab89
`define MD5_IV_C 32'h98badcfe
`define MD5_IV_D 32'h10325476

`endif

//--- src/md5_pkg.sv
`default_nettype none

`include "md5_cfg.svh"

package md5_pkg;

        typedef logic [31:0] word_t;
        typedef logic [`MD5_MSG_BITS-1:0] msg_t;
        typedef logic [127:0] digest_t;
        typedef logic [$clog2(`MD5_ROUNDS)-1:0] round_idx_t;

        ////////////////////////////////////////
        // round constants
        ////////////////////////////////////////

        // floor(abs(sin(i + 1)) * 2^32)
        localparam word_t k_table [0:63] = '{
                32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
                32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
                32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
                32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
                32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
                32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
                32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
                32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
                32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
                32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
                32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
                32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
                32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
                32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
                32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
                32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
        };

        // rows are the four round groups
        localparam logic [4:0] shift_table [0:3][0:3] = '{
                '{5'd7, 5'd12, 5'd17, 5'd22},
                '{5'd5, 5'd9,  5'd14, 5'd20},
                '{5'd4, 5'd11, 5'd16, 5'd23},
                '{5'd6, 5'd10, 5'd15, 5'd21}
        };

        ////////////////////////////////////////
        // per-round lookups
        ////////////////////////////////////////

        function automatic word_t md5_k(round_idx_t r);
                return k_table[r];
        endfunction

        function automatic logic [4:0] md5_shift(round_idx_t r);
                return shift_table[r[5:4]][r[1:0]];
        endfunction

        // index of the message word consumed by round r
        function automatic logic [3:0] md5_word_index(round_idx_t r);
                int unsigned i;
                int unsigned idx;
                i = r;
                case (r[5:4])
                        2'd0: idx = i;
                        2'd1: idx = 5 * i + 1;
                        2'd2: idx = 3 * i + 5;
                        default: idx = 7 * i;
                endcase
                return idx[3:0];
        endfunction

        // little-endian word <-> byte stream order
        function automatic word_t md5_bswap(word_t w);
                return {w[7:0], w[15:8], w[23:16], w[31:24]};
        endfunction

endpackage

`default_nettype wire

//--- src/md5_round_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_cfg.svh"

module md5_round_stage import md5_pkg::*; #(
        parameter round_idx_t ROUND = '0
) (
        input  logic  clk,
        input  logic  rst_n,
        input  logic  valid_in,
        input  word_t a_in,
        input  word_t b_in,
        input  word_t c_in,
        input  word_t d_in,
        input  msg_t  msg_in,
        output logic  valid_out,
        output word_t a_out,
        output word_t b_out,
        output word_t c_out,
        output word_t d_out,
        output msg_t  msg_out
);

        localparam logic [1:0] round_grp = ROUND[5:4];
        localparam word_t      k_val     = md5_k(ROUND);
        localparam logic [4:0] shift_amt = md5_shift(ROUND);
        localparam logic [3:0] word_idx  = md5_word_index(ROUND);

        // first padding byte right after the eight message bytes
        localparam word_t pad_word = 32'h0000_0080;

        word_t f_val;
        word_t m_val;
        word_t sum;
        word_t rot;

        ////////////////////////////////////////
        // round function and message word
        ////////////////////////////////////////

        always_comb begin
                case (round_grp)
                        2'd0: f_val = (b_in & c_in) | (~b_in & d_in);
                        2'd1: f_val = (d_in & b_in) | (~d_in & c_in);
                        2'd2: f_val = b_in ^ c_in ^ d_in;
                        default: f_val = c_in ^ (b_in | ~d_in);
                endcase
        end

        // words 3..13 and 15 are zero for an eight-byte block
        always_comb begin
                case (word_idx)
                        4'd0: m_val = msg_in[63:32];
                        4'd1: m_val = msg_in[31:0];
                        4'd2: m_val = pad_word;
                        4'd14: m_val = word_t'(`MD5_MSG_BITS);
                        default: m_val = '0;
                endcase
        end

        assign sum = a_in + f_val + k_val + m_val;
        assign rot = (sum << shift_amt) | (sum >> (6'd32 - shift_amt));

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        valid_out <= 1'b0;
                end else begin
                        valid_out <= valid_in;
                end
        end

        // state rotates: d->a, b->c, c->d
        always_ff @(posedge clk) begin
                a_out   <= d_in;
                b_out   <= b_in + rot;
                c_out   <= b_in;
                d_out   <= c_in;
                msg_out <= msg_in;
        end

        a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
                !$isunknown(valid_out));

endmodule

`default_nettype wire

//--- src/md5_digest_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_cfg.svh"

module md5_digest_out import md5_pkg::*; (
        input  logic    clk,
        input  logic    rst_n,
        input  logic    valid_in,
        input  word_t   a_in,
        input  word_t   b_in,
        input  word_t   c_in,
        input  word_t   d_in,
        input  msg_t    msg_in,
        output logic    out_valid,
        output digest_t out_digest,
        output msg_t    out_msg
);

        word_t fin_a;
        word_t fin_b;
        word_t fin_c;
        word_t fin_d;

        // add back the chaining value of the single block
        assign fin_a = a_in + `MD5_IV_A;
        assign fin_b = b_in + `MD5_IV_B;
        assign fin_c = c_in + `MD5_IV_C;
        assign fin_d = d_in + `MD5_IV_D;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= valid_in;
                end
        end

        // digest as a byte string, first byte in the top bits
        always_ff @(posedge clk) begin
                out_digest <= {md5_bswap(fin_a), md5_bswap(fin_b),
                               md5_bswap(fin_c), md5_bswap(fin_d)};
                out_msg    <= {md5_bswap(msg_in[63:32]), md5_bswap(msg_in[31:0])};
        end

        a_rst_clears_out: assert property (@(posedge clk) !rst_n |=> !out_valid);

endmodule

`default_nettype wire

//--- src/md5_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "md5_cfg.svh"

module md5_core import md5_pkg::*; (
        input  logic    clk,
        input  logic    rst_n,
        input  logic    in_valid,
        input  msg_t    in_msg,
        output logic    out_valid,
        output digest_t out_digest,
        output msg_t    out_msg
);

        logic  in_valid_q;
        msg_t  in_msg_q;
        word_t iv_a_q;
        word_t iv_b_q;
        word_t iv_c_q;
        word_t iv_d_q;

        // element 0 is the input register, element i+1 the output of round i
        logic  valid_chain [0:`MD5_ROUNDS];
        word_t a_chain     [0:`MD5_ROUNDS];
        word_t b_chain     [0:`MD5_ROUNDS];
        word_t c_chain     [0:`MD5_ROUNDS];
        word_t d_chain     [0:`MD5_ROUNDS];
        msg_t  msg_chain   [0:`MD5_ROUNDS];

        ////////////////////////////////////////
        // input register
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        in_valid_q <= 1'b0;
                end else begin
                        in_valid_q <= in_valid;
                end
        end

        // halves become little-endian words 0 and 1
        always_ff @(posedge clk) begin
                in_msg_q <= {md5_bswap(in_msg[63:32]), md5_bswap(in_msg[31:0])};
                iv_a_q   <= `MD5_IV_A;
                iv_b_q   <= `MD5_IV_B;
                iv_c_q   <= `MD5_IV_C;
                iv_d_q   <= `MD5_IV_D;
        end

        assign valid_chain[0] = in_valid_q;
        assign a_chain[0]     = iv_a_q;
        assign b_chain[0]     = iv_b_q;
        assign c_chain[0]     = iv_c_q;
        assign d_chain[0]     = iv_d_q;
        assign msg_chain[0]   = in_msg_q;

        ////////////////////////////////////////
        // round pipeline
        ////////////////////////////////////////

        for (genvar g = 0; g < `MD5_ROUNDS; g++) begin : g_round
                md5_round_stage #(
                        .ROUND(round_idx_t'(g))
                ) u_round (
                        .clk      (clk),
                        .rst_n    (rst_n),
                        .valid_in (valid_chain[g]),
                        .a_in     (a_chain[g]),
                        .b_in     (b_chain[g]),
                        .c_in     (c_chain[g]),
                        .d_in     (d_chain[g]),
                        .msg_in   (msg_chain[g]),
                        .valid_out(valid_chain[g+1]),
                        .a_out    (a_chain[g+1]),
                        .b_out    (b_chain[g+1]),
                        .c_out    (c_chain[g+1]),
                        .d_out    (d_chain[g+1]),
                        .msg_out  (msg_chain[g+1])
                );
        end

        md5_digest_out u_digest_out (
                .clk       (clk),
                .rst_n     (rst_n),
                .valid_in  (valid_chain[`MD5_ROUNDS]),
                .a_in      (a_chain[`MD5_ROUNDS]),
                .b_in      (b_chain[`MD5_ROUNDS]),
                .c_in      (c_chain[`MD5_ROUNDS]),
                .d_in      (d_chain[`MD5_ROUNDS]),
                .msg_in    (msg_chain[`MD5_ROUNDS]),
                .out_valid (out_valid),
                .out_digest(out_digest),
                .out_msg   (out_msg)
        );

        a_in_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
                !$isunknown(in_valid));

endmodule

`default_nettype wire

//--- test/tb_md5_model.svh
`ifndef TB_MD5_MODEL_SVH
`define TB_MD5_MODEL_SVH

function automatic logic [31:0] ref_rotl(logic [31:0] x, int n);
        return (x << n) | (x >> (32 - n));
endfunction

// K[i] = floor(abs(sin(i + 1)) * 2^32)
function automatic logic [31:0] ref_k(int i);
        real s;
        longint v;
        s = $sin(real'(i + 1));
        if (s < 0.0) begin
                s = -s;
        end
        v = longint'($floor(s * 4294967296.0));
        return v[31:0];
endfunction

////////////////////////////////////////
// reference MD5 of one eight-byte message
////////////////////////////////////////

function automatic digest_t md5_ref(msg_t msg);
        logic [7:0] blk [0:63];
        logic [31:0] w [0:15];
        logic [31:0] st [0:3];
        int sh [0:15];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] f;
        logic [31:0] tmp;
        int g;
        int i;
        int j;
        digest_t dig;
        sh = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
        // message, 0x80 marker, zero fill, bit length little-endian
        for (j = 0; j < 64; j++) begin
                blk[j] = 8'h00;
        end
        for (j = 0; j < 8; j++) begin
                blk[j] = msg[63 - 8 * j -: 8];
        end
        blk[8] = 8'h80;
        blk[56] = 8'd64;
        for (j = 0; j < 16; j++) begin
                w[j] = {blk[4 * j + 3], blk[4 * j + 2], blk[4 * j + 1], blk[4 * j]};
        end
        st = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};
        a = st[0];
        b = st[1];
        c = st[2];
        d = st[3];
        for (i = 0; i < 64; i++) begin
                case (i / 16)
                        0: begin
                                f = (b & c) | (~b & d);
                                g = i;
                        end
                        1: begin
                                f = (d & b) | (~d & c);
                                g = (5 * i + 1) % 16;
                        end
                        2: begin
                                f = b ^ c ^ d;
                                g = (3 * i + 5) % 16;
                        end
                        default: begin
                                f = c ^ (b | ~d);
                                g = (7 * i) % 16;
                        end
                endcase
                tmp = d;
                d = c;
                c = b;
                b = b + ref_rotl(a + f + ref_k(i) + w[g], sh[(i / 16) * 4 + i % 4]);
                a = tmp;
        end
        st[0] = st[0] + a;
        st[1] = st[1] + b;
        st[2] = st[2] + c;
        st[3] = st[3] + d;
        // each word goes out low byte first
        for (j = 0; j < 16; j++) begin
                dig[127 - 8 * j -: 8] = st[j / 4][8 * (j % 4) +: 8];
        end
        return dig;
endfunction

`endif

//--- test/tb_md5_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_md5_core
        import md5_pkg::*;
();

        localparam int latency = 66;
        localparam int drain_limit = 400;

        logic    clk;
        logic    rst_n;
        logic    in_valid;
        msg_t    in_msg;
        logic    out_valid;
        digest_t out_digest;
        msg_t    out_msg;

        int      cyc = 0;
        digest_t exp_dig [$];
        msg_t    exp_msg [$];
        int      exp_cyc [$];

        `include "tb_md5_model.svh"

        md5_core UUT (
                .clk       (clk),
                .rst_n     (rst_n),
                .in_valid  (in_valid),
                .in_msg    (in_msg),
                .out_valid (out_valid),
                .out_digest(out_digest),
                .out_msg   (out_msg)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #5 clk = ~clk;
                end
        end

        always @(posedge clk) begin
                cyc <= cyc + 1;
        end

        ////////////////////////////////////////
        // error handling and stimulus helpers
        ////////////////////////////////////////

        task automatic abort_run();
                $display("ERRORS FOUND");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic report_value(string name, logic [127:0] exp, logic [127:0] act);
                $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
                abort_run();
        endtask

        task automatic report_text(string what);
                $display("%s (at %0t ns)", what, $time);
                abort_run();
        endtask

        function automatic msg_t random_msg();
                return {$urandom(), $urandom()};
        endfunction

        task automatic apply_reset();
                @(posedge clk);
                rst_n    <= 1'b0;
                in_valid <= 1'b0;
                repeat (10) @(posedge clk);
                rst_n <= 1'b1;
        endtask

        task automatic send_msg(msg_t m);
                @(posedge clk);
                in_valid <= 1'b1;
                in_msg   <= m;
        endtask

        // data keeps changing while in_valid is low
        task automatic idle(int n);
                repeat (n) begin
                        @(posedge clk);
                        in_valid <= 1'b0;
                        in_msg   <= random_msg();
                end
        endtask

        task automatic wait_drain();
                int n;
                n = 0;
                while (exp_cyc.size() != 0) begin
                        @(posedge clk);
                        n++;
                        assert (n <= drain_limit)
                        else report_text("timeout waiting for the pipeline to drain");
                end
        endtask

        ////////////////////////////////////////
        // output monitor on the falling edge
        ////////////////////////////////////////

        always @(negedge clk) begin
                if (cyc > 0) begin
                        assert (!$isunknown(out_valid))
                        else report_text("out_valid is unknown after the first clock");
                end
                if (out_valid === 1'b1) begin
                        assert (exp_cyc.size() > 0)
                        else report_text("out_valid went high with no message in flight");
                        assert (exp_cyc[0] == cyc)
                        else report_value("out_valid cycle", exp_cyc[0], cyc);
                        assert (out_digest === exp_dig[0])
                        else report_value("out_digest", exp_dig[0], out_digest);
                        assert (out_msg === exp_msg[0])
                        else report_value("out_msg", exp_msg[0], out_msg);
                        void'(exp_dig.pop_front());
                        void'(exp_msg.pop_front());
                        void'(exp_cyc.pop_front());
                end else if (exp_cyc.size() > 0) begin
                        assert (exp_cyc[0] != cyc)
                        else report_text("out_valid missing for an expected digest");
                end
                // a reset drops everything in flight
                if (rst_n !== 1'b1) begin
                        exp_dig.delete();
                        exp_msg.delete();
                        exp_cyc.delete();
                end else if (in_valid === 1'b1) begin
                        exp_dig.push_back(md5_ref(in_msg));
                        exp_msg.push_back(in_msg);
                        exp_cyc.push_back(cyc + latency);
                end
        end

        initial begin
                int n;
                logic [7:0] byte_pat;
                rst_n    = 1'b0;
                in_valid = 1'b0;
                in_msg   = '0;
                void'($urandom(32'hfaf395fe));

                // known answer for the reference model
                assert (md5_ref(64'h3132333435363738) ===
                        128'h25d55ad283aa400af464c76d713c07ad)
                else report_value("md5_ref", 128'h25d55ad283aa400af464c76d713c07ad,
                                  md5_ref(64'h3132333435363738));

                apply_reset();
                idle(2 * latency);

                // single messages
                send_msg(64'h3132333435363738);
                idle(1);
                wait_drain();
                send_msg(random_msg());
                idle(1);
                wait_drain();

                // back-to-back stream
                repeat (200) send_msg(random_msg());
                idle(1);
                wait_drain();

                // random gaps in in_valid
                repeat (300) begin
                        if ($urandom_range(0, 2) == 0) begin
                                idle(1);
                        end else begin
                                send_msg(random_msg());
                        end
                end
                idle(1);
                wait_drain();

                // corner messages
                send_msg('0);
                send_msg('1);
                for (n = 0; n < 8; n++) begin
                        byte_pat = 8'h01 << n;
                        send_msg({8{byte_pat}});
                end
                for (n = 0; n < 64; n++) begin
                        send_msg(msg_t'(1) << n);
                end
                idle(1);
                wait_drain();

                // reset in the middle of a stream
                repeat (40) send_msg(random_msg());
                apply_reset();
                idle(2 * latency);
                repeat (20) send_msg(random_msg());
                idle(1);
                wait_drain();
                idle(latency + 2);

                if (exp_cyc.size() != 0) begin
                        report_text("expected digests left over at the end of the run");
                end else begin
                        $display("NO ERRORS");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- md5_core.f
+incdir+src
+incdir+test
src/md5_pkg.sv
src/md5_round_stage.sv
src/md5_digest_out.sv
src/md5_core.sv
test/tb_md5_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the md5_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f md5_core.f \
        --top-module tb_md5_core -o tb_md5_core
if [ $? -ne 0 ]; then
        echo "compile step failed"
        exit 1
fi

./obj_dir/tb_md5_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
        echo "simulation passed"
        exit 0
else
        echo "simulation failed"
        exit 1
fi
